//--- Bender.yml
package:
  name: tg_axil_trafgen

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - tg_pkg.sv
      - tg_axil_if.sv
      - tg_prbs_addr_gen.sv
      - tg_write_gen.sv
      - tg_read_check.sv
      - tg_axil_arbiter.sv
      - tg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_axil_mem.sv
      - tb_tg_top.sv

//--- project.f
+incdir+.
tg_pkg.sv
tg_axil_if.sv
tg_prbs_addr_gen.sv
tg_write_gen.sv
tg_read_check.sv
tg_axil_arbiter.sv
tg_top.sv
tb_axil_mem.sv
tb_tg_top.sv

//--- tb_axil_mem.sv
`include "tg_cfg.svh"

module tb_axil_mem (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  stall_en_i,
  input  logic                  corrupt_en_i,
  input  logic                  slverr_en_i,
  input  tg_pkg::tg_addr_t      fault_addr_i,
  input  tg_pkg::tg_addr_t      awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  tg_pkg::tg_data_t      wdata_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output tg_pkg::tg_resp_t      bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  tg_pkg::tg_addr_t      araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output tg_pkg::tg_data_t      rdata_o,
  output tg_pkg::tg_resp_t      rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i
);
  import tg_pkg::*;

  tg_data_t mem [0:1023];  // one word per window slot.
  integer   seed;
  logic     aw_got_q;
  logic     w_got_q;
  logic     bvalid_q;
  logic     rvalid_q;
  logic     aw_stall_q;
  logic     w_stall_q;
  logic     ar_stall_q;
  tg_addr_t aw_addr_q;
  tg_data_t w_data_q;
  tg_resp_t bresp_q;
  tg_data_t rdata_q;

  initial begin
    seed = 53863;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'hBAD0_0000 | i;
    end
  end

  // outputs move a little after the edge, like the rest of the stimulus.
  assign #10 awready_o = !aw_got_q && !aw_stall_q;
  assign #10 wready_o  = !w_got_q && !w_stall_q;
  assign #10 bvalid_o  = bvalid_q;
  assign #10 bresp_o   = bresp_q;
  assign #10 arready_o = !rvalid_q && !ar_stall_q;
  assign #10 rvalid_o  = rvalid_q;
  assign #10 rdata_o   = rdata_q;
  assign #10 rresp_o   = 2'b00;

  always @(posedge clk_i) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    if (reset_i) begin
      aw_got_q   <= 1'b0;
      w_got_q    <= 1'b0;
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      aw_stall_q <= 1'b0;
      w_stall_q  <= 1'b0;
      ar_stall_q <= 1'b0;
      bresp_q    <= 2'b00;
    end else begin
      aw_stall_q <= stall_en_i && (rnd[1:0] == 2'b00);
      w_stall_q  <= stall_en_i && (rnd[3:2] == 2'b00);
      ar_stall_q <= stall_en_i && (rnd[5:4] == 2'b00);
      if (awvalid_i && awready_o) begin
        aw_got_q  <= 1'b1;
        aw_addr_q <= awaddr_i;
      end
      if (wvalid_i && wready_o) begin
        w_got_q  <= 1'b1;
        w_data_q <= wdata_i;
      end
      // store once both halves are in; the data is kept even on SLVERR.
      if (aw_got_q && w_got_q && !bvalid_q) begin
        mem[aw_addr_q[11:2]] <= w_data_q;
        bvalid_q <= 1'b1;
        bresp_q  <= (slverr_en_i && aw_addr_q == fault_addr_i) ? 2'b10 : 2'b00;
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
      end
      if (bvalid_o && bready_i) bvalid_q <= 1'b0;
      if (arvalid_i && arready_o) begin
        rvalid_q <= 1'b1;
        rdata_q  <= mem[araddr_i[11:2]] ^
                    ((corrupt_en_i && araddr_i == fault_addr_i) ? 32'h0000_0100 : 32'h0);
      end
      if (rvalid_o && rready_i) rvalid_q <= 1'b0;
    end
  end

endmodule

//--- tb_tg_top.sv
`include "tg_cfg.svh"

module tb_tg_top;
  import tg_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int TOTAL_TXN  = 64 + 500 + 100 + 40 + 64;

  logic                  clk;
  logic                  reset;
  logic                  start;
  tg_addr_t              seed;
  tg_cnt_t               count_in;
  logic                  busy;
  logic                  done;
  logic                  error;
  tg_cnt_t               err_cnt;
  tg_addr_t              first_err_addr;

  tg_addr_t              m_awaddr;
  logic                  m_awvalid;
  logic                  m_awready;
  tg_data_t              m_wdata;
  logic [`TG_STRB_W-1:0] m_wstrb;
  logic                  m_wvalid;
  logic                  m_wready;
  tg_resp_t              m_bresp;
  logic                  m_bvalid;
  logic                  m_bready;
  tg_addr_t              m_araddr;
  logic                  m_arvalid;
  logic                  m_arready;
  tg_data_t              m_rdata;
  tg_resp_t              m_rresp;
  logic                  m_rvalid;
  logic                  m_rready;

  logic                  stall_en;
  logic                  corrupt_en;
  logic                  slverr_en;
  tg_addr_t              fault_addr;

  tg_addr_t              pred_addr [0:1023];  // reference address sequence.
  logic                  b_seen [0:1023];
  int                    aw_cnt;
  int                    w_cnt;
  int                    ar_cnt;
  int                    open_cnt;
  tg_addr_t              open_addr;
  tg_addr_t              exp_awaddr;
  tg_addr_t              exp_araddr;
  tg_data_t              exp_wdata;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  b_hs;
  logic                  ar_hs;
  logic                  r_hs;
  logic                  ar_written;

  string                 test_name;
  int                    fail_count;
  int                    test_count;
  int                    tests_failed;

  tg_top dut (
    .clk_i (clk), .reset_i (reset), .start_i (start), .seed_i (seed), .count_i (count_in),
    .busy_o (busy), .done_o (done), .error_o (error), .err_cnt_o (err_cnt),
    .first_err_addr_o (first_err_addr),
    .m_axil_awaddr_o (m_awaddr), .m_axil_awvalid_o (m_awvalid), .m_axil_awready_i (m_awready),
    .m_axil_wdata_o (m_wdata), .m_axil_wstrb_o (m_wstrb), .m_axil_wvalid_o (m_wvalid),
    .m_axil_wready_i (m_wready), .m_axil_bresp_i (m_bresp), .m_axil_bvalid_i (m_bvalid),
    .m_axil_bready_o (m_bready), .m_axil_araddr_o (m_araddr), .m_axil_arvalid_o (m_arvalid),
    .m_axil_arready_i (m_arready), .m_axil_rdata_i (m_rdata), .m_axil_rresp_i (m_rresp),
    .m_axil_rvalid_i (m_rvalid), .m_axil_rready_o (m_rready)
  );

  tb_axil_mem u_mem (
    .clk_i (clk), .reset_i (reset), .stall_en_i (stall_en), .corrupt_en_i (corrupt_en),
    .slverr_en_i (slverr_en), .fault_addr_i (fault_addr),
    .awaddr_i (m_awaddr), .awvalid_i (m_awvalid), .awready_o (m_awready),
    .wdata_i (m_wdata), .wvalid_i (m_wvalid), .wready_o (m_wready),
    .bresp_o (m_bresp), .bvalid_o (m_bvalid), .bready_i (m_bready),
    .araddr_i (m_araddr), .arvalid_i (m_arvalid), .arready_o (m_arready),
    .rdata_o (m_rdata), .rresp_o (m_rresp), .rvalid_o (m_rvalid), .rready_i (m_rready)
  );

  function automatic tg_addr_t lfsr_next(input tg_addr_t x);
    tg_addr_t y;
    y = {x[30:0], x[31]};
    if (x[31]) y = y ^ 32'h0000_00C4;  // taps on bits 2, 6 and 7.
    return y;
  endfunction

  function automatic tg_addr_t window_of(input tg_addr_t x);
    return (x & ~`TG_ADDR_CLR_MASK) | `TG_ADDR_SET_MASK;
  endfunction

  function automatic tg_data_t expected_data(input tg_addr_t a);
    return {a[23:0], a[31:24]} ^ `TG_DATA_KEY;
  endfunction

  function automatic logic in_window(input tg_addr_t a);
    return (a >= 32'h1000) && (a <= 32'h1FFC) && (a[1:0] == 2'b00);
  endfunction

  function automatic int count_hits(input tg_addr_t a, input int n);
    int hits;
    hits = 0;
    for (int k = 0; k < n; k++) begin
      if (pred_addr[k] == a) hits++;
    end
    return hits;
  endfunction

  task automatic predict_addresses(input tg_addr_t seed_val, input int n);
    tg_addr_t s;
    s = (seed_val == '0) ? 32'd1 : seed_val;
    for (int k = 0; k < n; k++) begin
      pred_addr[k] = window_of(s);
      s = lfsr_next(s);
    end
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    fail_count++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR in %s: %s", test_name, what);
    fail_count++;
  endtask

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else report_mismatch(what, exp, act);
  endtask

  task automatic configure_memory(input logic stalls, input logic corrupt, input logic slverr,
                                  input tg_addr_t target);
    @(posedge clk);
    #10;
    stall_en   = stalls;
    corrupt_en = corrupt;
    slverr_en  = slverr;
    fault_addr = target;
  endtask

  task automatic run_test(input string name, input tg_addr_t seed_val, input int count,
                          input int exp_errs, input logic exp_error, input tg_addr_t exp_first);
    int fails_before;
    test_name    = name;
    fails_before = fail_count;
    @(posedge clk);
    #10;
    seed     = seed_val;
    count_in = tg_cnt_t'(count);
    start    = 1'b1;
    @(posedge clk);
    #10;
    start = 1'b0;
    @(negedge clk);
    expect_eq("err_cnt after start", 0, err_cnt);  // counters clear on a new run.
    expect_eq("error after start", 0, error);
    expect_eq("done after start", 0, done);
    expect_eq("busy after start", 1, busy);
    while (!done) @(negedge clk);
    expect_eq("busy at done", 0, busy);
    expect_eq("writes", count, aw_cnt);
    expect_eq("reads", count, ar_cnt);
    expect_eq("err_cnt", exp_errs, err_cnt);
    expect_eq("error", exp_error, error);
    if (exp_errs != 0) expect_eq("first_err_addr", exp_first, first_err_addr);
    test_count++;
    if (fail_count == fails_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, fail_count - fails_before);
    end
  endtask

  assign aw_hs      = m_awvalid && m_awready;
  assign w_hs       = m_wvalid && m_wready;
  assign b_hs       = m_bvalid && m_bready;
  assign ar_hs      = m_arvalid && m_arready;
  assign r_hs       = m_rvalid && m_rready;
  assign exp_awaddr = pred_addr[aw_cnt];
  assign exp_wdata  = expected_data(pred_addr[w_cnt]);
  assign exp_araddr = pred_addr[ar_cnt];
  assign ar_written = b_seen[m_araddr[11:2]];

  // shared port monitor, cleared when the DUT takes a start.
  always @(posedge clk) begin
    if (reset || (start && !busy)) begin
      aw_cnt   <= 0;
      w_cnt    <= 0;
      ar_cnt   <= 0;
      open_cnt <= 0;
      for (int i = 0; i < 1024; i++) begin
        b_seen[i] <= 1'b0;
      end
    end else begin
      if (aw_hs) begin
        aw_cnt    <= aw_cnt + 1;
        open_addr <= m_awaddr;
      end
      if (w_hs) w_cnt <= w_cnt + 1;
      if (ar_hs) ar_cnt <= ar_cnt + 1;
      if (b_hs) b_seen[open_addr[11:2]] <= 1'b1;
      open_cnt <= open_cnt + int'(aw_hs) + int'(ar_hs) - int'(b_hs) - int'(r_hs);
    end
  end

  aw_addr_seq: assert property (@(posedge clk) disable iff (reset)
    aw_hs |-> (m_awaddr == exp_awaddr))
    else report_mismatch("awaddr", $sampled(exp_awaddr), $sampled(m_awaddr));
  ar_addr_seq: assert property (@(posedge clk) disable iff (reset)
    ar_hs |-> (m_araddr == exp_araddr))
    else report_mismatch("araddr", $sampled(exp_araddr), $sampled(m_araddr));
  w_data_val: assert property (@(posedge clk) disable iff (reset)
    w_hs |-> (m_wdata == exp_wdata))
    else report_mismatch("wdata", $sampled(exp_wdata), $sampled(m_wdata));
  w_strb_val: assert property (@(posedge clk) disable iff (reset)
    w_hs |-> (m_wstrb == '1))
    else report_mismatch("wstrb", 32'hF, $sampled(m_wstrb));
  aw_window: assert property (@(posedge clk) disable iff (reset)
    m_awvalid |-> in_window(m_awaddr))
    else report_problem($sformatf("awaddr %h is outside the window", $sampled(m_awaddr)));
  ar_window: assert property (@(posedge clk) disable iff (reset)
    m_arvalid |-> in_window(m_araddr))
    else report_problem($sformatf("araddr %h is outside the window", $sampled(m_araddr)));
  read_after_write: assert property (@(posedge clk) disable iff (reset)
    ar_hs |-> ar_written)
    else report_problem($sformatf("read of %h before its write response",
                                  $sampled(m_araddr)));
  aw_hold: assert property (@(posedge clk) disable iff (reset)
    (m_awvalid && !m_awready) |=> (m_awvalid && $stable(m_awaddr)))
    else report_problem("awvalid dropped or awaddr changed before awready");
  w_hold: assert property (@(posedge clk) disable iff (reset)
    (m_wvalid && !m_wready) |=> (m_wvalid && $stable(m_wdata)))
    else report_problem("wvalid dropped or wdata changed before wready");
  ar_hold: assert property (@(posedge clk) disable iff (reset)
    (m_arvalid && !m_arready) |=> (m_arvalid && $stable(m_araddr)))
    else report_problem("arvalid dropped or araddr changed before arready");
  one_open: assert property (@(posedge clk) disable iff (reset)
    open_cnt <= 1)
    else report_problem("more than one transaction open on the shared port");

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PERIOD * (200 * TOTAL_TXN + 10));
    $display("watchdog expired while test %s was running", test_name);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    start        = 1'b0;
    seed         = '0;
    count_in     = '0;
    stall_en     = 1'b0;
    corrupt_en   = 1'b0;
    slverr_en    = 1'b0;
    fault_addr   = '0;
    fail_count   = 0;
    test_count   = 0;
    tests_failed = 0;
    test_name    = "reset";
    repeat (3) @(posedge clk);
    #10;
    reset = 1'b0;

    predict_addresses(32'd1, 64);
    configure_memory(1'b0, 1'b0, 1'b0, '0);
    run_test("clean", 32'd1, 64, 0, 1'b0, '0);

    predict_addresses(32'h1234_5678, 500);
    configure_memory(1'b1, 1'b0, 1'b0, '0);
    run_test("long_stalls", 32'h1234_5678, 500, 0, 1'b0, '0);

    predict_addresses(32'd7, 100);
    configure_memory(1'b1, 1'b1, 1'b0, pred_addr[9]);  // 10th address reads back wrong.
    run_test("corrupt", 32'd7, 100, count_hits(pred_addr[9], 100), 1'b1, pred_addr[9]);

    predict_addresses(32'd9, 40);
    configure_memory(1'b0, 1'b0, 1'b1, pred_addr[5]);
    run_test("slverr", 32'd9, 40, 0, 1'b1, '0);

    predict_addresses(32'hCAFE_F00D, 64);
    configure_memory(1'b1, 1'b0, 1'b0, '0);
    run_test("reseed", 32'hCAFE_F00D, 64, 0, 1'b0, '0);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             test_count, tests_failed, fail_count);
    if (fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- tg_axil_arbiter.sv
module tg_axil_arbiter (
  input  logic   clk_i,
  input  logic   reset_i,
  tg_axil_if.slv m0,
  tg_axil_if.slv m1,
  tg_axil_if.mst s
);
  import tg_pkg::*;

  tg_arb_state_e state_q;
  logic          last_q;  // master served last.
  logic          req0;
  logic          req1;
  logic          gnt0;
  logic          gnt1;
  logic          txn_end;

  assign req0 = m0.awvalid || m0.arvalid;
  assign req1 = m1.awvalid || m1.arvalid;
  assign gnt0 = (state_q == ARB_GRANT0);
  assign gnt1 = (state_q == ARB_GRANT1);

  // payloads follow the grant, valids only from the granted side.
  assign s.awaddr  = gnt1 ? m1.awaddr : m0.awaddr;
  assign s.awvalid = (gnt0 && m0.awvalid) || (gnt1 && m1.awvalid);
  assign s.wdata   = gnt1 ? m1.wdata : m0.wdata;
  assign s.wstrb   = gnt1 ? m1.wstrb : m0.wstrb;
  assign s.wvalid  = (gnt0 && m0.wvalid) || (gnt1 && m1.wvalid);
  assign s.bready  = (gnt0 && m0.bready) || (gnt1 && m1.bready);
  assign s.araddr  = gnt1 ? m1.araddr : m0.araddr;
  assign s.arvalid = (gnt0 && m0.arvalid) || (gnt1 && m1.arvalid);
  assign s.rready  = (gnt0 && m0.rready) || (gnt1 && m1.rready);

  assign m0.awready = gnt0 && s.awready;
  assign m0.wready  = gnt0 && s.wready;
  assign m0.bresp   = s.bresp;
  assign m0.bvalid  = gnt0 && s.bvalid;
  assign m0.arready = gnt0 && s.arready;
  assign m0.rdata   = s.rdata;
  assign m0.rresp   = s.rresp;
  assign m0.rvalid  = gnt0 && s.rvalid;

  assign m1.awready = gnt1 && s.awready;
  assign m1.wready  = gnt1 && s.wready;
  assign m1.bresp   = s.bresp;
  assign m1.bvalid  = gnt1 && s.bvalid;
  assign m1.arready = gnt1 && s.arready;
  assign m1.rdata   = s.rdata;
  assign m1.rresp   = s.rresp;
  assign m1.rvalid  = gnt1 && s.rvalid;

  // a grant ends with the response of its one transaction.
  assign txn_end = (s.bvalid && s.bready) || (s.rvalid && s.rready);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ARB_IDLE;
      last_q  <= 1'b1;  // m0 goes first.
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (req0 && (!req1 || last_q)) begin
            state_q <= ARB_GRANT0;
          end else if (req1) begin
            state_q <= ARB_GRANT1;
          end
        end
        ARB_GRANT0: begin
          if (txn_end) begin
            state_q <= ARB_IDLE;
            last_q  <= 1'b0;
          end
        end
        ARB_GRANT1: begin
          if (txn_end) begin
            state_q <= ARB_IDLE;
            last_q  <= 1'b1;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

endmodule

//--- tg_axil_if.sv
`include "tg_cfg.svh"

interface tg_axil_if;
  import tg_pkg::*;

  tg_addr_t             awaddr;
  logic                 awvalid;
  logic                 awready;
  tg_data_t             wdata;
  logic [`TG_STRB_W-1:0] wstrb;
  logic                 wvalid;
  logic                 wready;
  tg_resp_t             bresp;
  logic                 bvalid;
  logic                 bready;
  tg_addr_t             araddr;
  logic                 arvalid;
  logic                 arready;
  tg_data_t             rdata;
  tg_resp_t             rresp;
  logic                 rvalid;
  logic                 rready;

  modport mst (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slv (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

//--- tg_cfg.svh
`ifndef TG_CFG_SVH
`define TG_CFG_SVH

// bus widths.
`define TG_ADDR_W 32
`define TG_DATA_W 32
`define TG_STRB_W (`TG_DATA_W / 8)

// transaction and error counters.
`define TG_CNT_W 16

// address window: clear first, then set.
`define TG_ADDR_CLR_MASK 32'hFFFF_F003  // bits 31:12 and 1:0.
`define TG_ADDR_SET_MASK 32'h0000_1000  // window base 0x1000.

// mixed into every data word.
`define TG_DATA_KEY 32'hA5C3_5A3C

`endif

//--- tg_pkg.sv
`include "tg_cfg.svh"

package tg_pkg;

  typedef logic [`TG_ADDR_W-1:0] tg_addr_t;
  typedef logic [`TG_DATA_W-1:0] tg_data_t;
  typedef logic [`TG_CNT_W-1:0]  tg_cnt_t;
  typedef logic [1:0]            tg_resp_t;  // OKAY is 2'b00.

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_RESP} tg_wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_RESP} tg_rd_state_e;
  typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT0, ARB_GRANT1} tg_arb_state_e;

  // expected word: address rotated left by one byte, then keyed.
  function automatic tg_data_t tg_data_of(input tg_addr_t addr);
    tg_addr_t rot;
    rot = {addr[`TG_ADDR_W-9:0], addr[`TG_ADDR_W-1:`TG_ADDR_W-8]};
    return tg_data_t'(rot) ^ `TG_DATA_KEY;
  endfunction

endpackage

//--- tg_prbs_addr_gen.sv
`include "tg_cfg.svh"

module tg_prbs_addr_gen (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             seed_load_i,
  input  tg_pkg::tg_addr_t seed_i,
  input  logic             step_i,
  output tg_pkg::tg_addr_t addr_o
);
  import tg_pkg::*;

  // feedback lands on bits 2, 6 and 7.
  localparam tg_addr_t TAPS = 32'h0000_00C4;

  tg_addr_t lfsr_q;
  tg_addr_t lfsr_next;
  tg_addr_t seed_fixed;
  logic     msb;

  assign msb = lfsr_q[`TG_ADDR_W-1];

  // shift left, msb wraps into bit 0.
  always_comb begin
    lfsr_next = {lfsr_q[`TG_ADDR_W-2:0], msb};
    if (msb) begin
      lfsr_next = lfsr_next ^ TAPS;
    end
  end

  assign seed_fixed = (seed_i == '0) ? tg_addr_t'(1) : seed_i;  // all-zero locks up.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q <= tg_addr_t'(1);
    end else if (seed_load_i) begin
      lfsr_q <= seed_fixed;
    end else if (step_i) begin
      lfsr_q <= lfsr_next;
    end
  end

  // window the raw state and drop the byte offset.
  assign addr_o = (lfsr_q & ~`TG_ADDR_CLR_MASK) | `TG_ADDR_SET_MASK;

endmodule

//--- tg_read_check.sv
module tg_read_check (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             start_i,
  input  tg_pkg::tg_cnt_t  count_i,
  tg_axil_if.mst           bus,
  output logic             addr_step_o,
  input  tg_pkg::tg_addr_t addr_i,
  input  tg_pkg::tg_cnt_t  wr_done_cnt_i,
  output tg_pkg::tg_cnt_t  err_cnt_o,
  output tg_pkg::tg_addr_t first_err_addr_o,
  output logic             done_o
);
  import tg_pkg::*;

  tg_rd_state_e state_q;
  tg_cnt_t      count_q;
  tg_cnt_t      rd_cnt_q;
  tg_cnt_t      err_cnt_q;
  tg_addr_t     first_err_q;
  tg_addr_t     rd_addr_q;
  logic         done_q;
  logic         ar_hs;
  logic         r_hs;
  logic         mismatch;

  // write channels unused.
  assign bus.awaddr  = '0;
  assign bus.awvalid = 1'b0;
  assign bus.wdata   = '0;
  assign bus.wstrb   = '0;
  assign bus.wvalid  = 1'b0;
  assign bus.bready  = 1'b0;

  // read k waits until write k has its B; the count only grows so valid holds.
  assign bus.araddr  = addr_i;
  assign bus.arvalid = (state_q == RD_ADDR) && (wr_done_cnt_i > rd_cnt_q);
  assign bus.rready  = (state_q == RD_RESP);

  assign ar_hs = bus.arvalid && bus.arready;
  assign r_hs  = bus.rvalid && bus.rready;

  assign mismatch = (bus.rdata != tg_data_of(rd_addr_q)) || (bus.rresp != '0);

  assign addr_step_o      = ar_hs;
  assign err_cnt_o        = err_cnt_q;
  assign first_err_addr_o = first_err_q;
  assign done_o           = done_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= RD_IDLE;
      count_q     <= '0;
      rd_cnt_q    <= '0;
      err_cnt_q   <= '0;
      first_err_q <= '0;
      done_q      <= 1'b0;
    end else begin
      case (state_q)
        RD_IDLE: begin
          if (start_i) begin
            count_q     <= count_i;
            rd_cnt_q    <= '0;
            err_cnt_q   <= '0;
            first_err_q <= '0;
            done_q      <= (count_i == '0);  // nothing to do.
            if (count_i != '0) begin
              state_q <= RD_ADDR;
            end
          end
        end
        RD_ADDR: begin
          if (ar_hs) state_q <= RD_RESP;
        end
        RD_RESP: begin
          if (r_hs) begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
            if (mismatch) begin
              err_cnt_q <= err_cnt_q + 1'b1;
              if (err_cnt_q == '0) first_err_q <= rd_addr_q;
            end
            if (rd_cnt_q + 1'b1 == count_q) begin
              done_q  <= 1'b1;
              state_q <= RD_IDLE;
            end else begin
              state_q <= RD_ADDR;
            end
          end
        end
        default: state_q <= RD_IDLE;
      endcase
    end
  end

  // outstanding address, since the LFSR steps on AR.
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rd_addr_q <= addr_i;
    end
  end

endmodule

//--- tg_top.sv
`include "tg_cfg.svh"

module tg_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  start_i,
  input  tg_pkg::tg_addr_t      seed_i,
  input  tg_pkg::tg_cnt_t       count_i,
  output logic                  busy_o,
  output logic                  done_o,
  output logic                  error_o,
  output tg_pkg::tg_cnt_t       err_cnt_o,
  output tg_pkg::tg_addr_t      first_err_addr_o,
  output tg_pkg::tg_addr_t      m_axil_awaddr_o,
  output logic                  m_axil_awvalid_o,
  input  logic                  m_axil_awready_i,
  output tg_pkg::tg_data_t      m_axil_wdata_o,
  output logic [`TG_STRB_W-1:0] m_axil_wstrb_o,
  output logic                  m_axil_wvalid_o,
  input  logic                  m_axil_wready_i,
  input  tg_pkg::tg_resp_t      m_axil_bresp_i,
  input  logic                  m_axil_bvalid_i,
  output logic                  m_axil_bready_o,
  output tg_pkg::tg_addr_t      m_axil_araddr_o,
  output logic                  m_axil_arvalid_o,
  input  logic                  m_axil_arready_i,
  input  tg_pkg::tg_data_t      m_axil_rdata_i,
  input  tg_pkg::tg_resp_t      m_axil_rresp_i,
  input  logic                  m_axil_rvalid_i,
  output logic                  m_axil_rready_o
);
  import tg_pkg::*;

  tg_axil_if wr_bus ();
  tg_axil_if rd_bus ();
  tg_axil_if mem_bus ();

  logic     start_ok;
  logic     wr_step;
  logic     rd_step;
  logic     wr_err;
  tg_addr_t wr_addr;
  tg_addr_t rd_addr;
  tg_cnt_t  wr_done_cnt;

  // some valid or response ready is up for the whole run.
  assign busy_o = wr_bus.awvalid || wr_bus.wvalid || wr_bus.bready ||
                  rd_bus.arvalid || rd_bus.rready;
  assign start_ok = start_i && !busy_o;  // restart only when idle.
  assign error_o  = (err_cnt_o != '0) || wr_err;

  tg_prbs_addr_gen u_wr_addr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .seed_load_i (start_ok),
    .seed_i      (seed_i),
    .step_i      (wr_step),
    .addr_o      (wr_addr)
  );

  tg_prbs_addr_gen u_rd_addr (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .seed_load_i (start_ok),
    .seed_i      (seed_i),
    .step_i      (rd_step),
    .addr_o      (rd_addr)
  );

  tg_write_gen u_write_gen (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .start_i       (start_ok),
    .count_i       (count_i),
    .bus           (wr_bus),
    .addr_step_o   (wr_step),
    .addr_i        (wr_addr),
    .wr_done_cnt_o (wr_done_cnt),
    .wr_err_o      (wr_err)
  );

  tg_read_check u_read_check (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .start_i          (start_ok),
    .count_i          (count_i),
    .bus              (rd_bus),
    .addr_step_o      (rd_step),
    .addr_i           (rd_addr),
    .wr_done_cnt_i    (wr_done_cnt),
    .err_cnt_o        (err_cnt_o),
    .first_err_addr_o (first_err_addr_o),
    .done_o           (done_o)
  );

  tg_axil_arbiter u_arbiter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .m0      (wr_bus),
    .m1      (rd_bus),
    .s       (mem_bus)
  );

  assign m_axil_awaddr_o  = mem_bus.awaddr;
  assign m_axil_awvalid_o = mem_bus.awvalid;
  assign m_axil_wdata_o   = mem_bus.wdata;
  assign m_axil_wstrb_o   = mem_bus.wstrb;
  assign m_axil_wvalid_o  = mem_bus.wvalid;
  assign m_axil_bready_o  = mem_bus.bready;
  assign m_axil_araddr_o  = mem_bus.araddr;
  assign m_axil_arvalid_o = mem_bus.arvalid;
  assign m_axil_rready_o  = mem_bus.rready;

  assign mem_bus.awready = m_axil_awready_i;
  assign mem_bus.wready  = m_axil_wready_i;
  assign mem_bus.bresp   = m_axil_bresp_i;
  assign mem_bus.bvalid  = m_axil_bvalid_i;
  assign mem_bus.arready = m_axil_arready_i;
  assign mem_bus.rdata   = m_axil_rdata_i;
  assign mem_bus.rresp   = m_axil_rresp_i;
  assign mem_bus.rvalid  = m_axil_rvalid_i;

endmodule

//--- tg_write_gen.sv
module tg_write_gen (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             start_i,
  input  tg_pkg::tg_cnt_t  count_i,
  tg_axil_if.mst           bus,
  output logic             addr_step_o,
  input  tg_pkg::tg_addr_t addr_i,
  output tg_pkg::tg_cnt_t  wr_done_cnt_o,
  output logic             wr_err_o
);
  import tg_pkg::*;

  tg_wr_state_e state_q;
  tg_cnt_t      count_q;
  tg_cnt_t      done_cnt_q;
  logic         aw_done_q;
  logic         w_done_q;
  logic         err_q;
  tg_data_t     wdata_q;
  logic         aw_hs;
  logic         w_hs;
  logic         b_hs;

  assign bus.awaddr  = addr_i;
  assign bus.awvalid = (state_q == WR_ADDR) && !aw_done_q;
  // addr_i moves on after AW, so W falls back to the held word.
  assign bus.wdata   = aw_done_q ? wdata_q : tg_data_of(addr_i);
  assign bus.wstrb   = '1;
  assign bus.wvalid  = (state_q == WR_ADDR) && !w_done_q;
  assign bus.bready  = (state_q == WR_RESP);

  // read channels unused.
  assign bus.araddr  = '0;
  assign bus.arvalid = 1'b0;
  assign bus.rready  = 1'b0;

  assign aw_hs = bus.awvalid && bus.awready;
  assign w_hs  = bus.wvalid && bus.wready;
  assign b_hs  = bus.bvalid && bus.bready;

  assign addr_step_o   = aw_hs;
  assign wr_done_cnt_o = done_cnt_q;
  assign wr_err_o      = err_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= WR_IDLE;
      count_q    <= '0;
      done_cnt_q <= '0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      case (state_q)
        WR_IDLE: begin
          if (start_i) begin
            count_q    <= count_i;
            done_cnt_q <= '0;
            err_q      <= 1'b0;
            if (count_i != '0) begin
              state_q <= WR_ADDR;
            end
          end
        end
        WR_ADDR: begin
          if (aw_hs) aw_done_q <= 1'b1;
          if (w_hs) w_done_q <= 1'b1;
          if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_hs) begin
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
            done_cnt_q <= done_cnt_q + 1'b1;
            if (bus.bresp != '0) err_q <= 1'b1;  // sticky.
            state_q <= (done_cnt_q + 1'b1 == count_q) ? WR_IDLE : WR_ADDR;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      wdata_q <= tg_data_of(addr_i);
    end
  end

endmodule
